// ==== rtl/valu.sv ====
`timescale 1ns/1ps
/*
 * Single-lane vector integer ALU
 * Instruction queue, issue stage, result buffer and commit tracker
 */
module valu (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Instruction
  input  valu_op_pkg::valu_op_e         op_i,
  input  valu_vec_pkg::vew_e            vsew_i,
  input  valu_vec_pkg::vlen_t           vl_i,
  input  valu_vec_pkg::vreg_t           vd_i,
  input  valu_op_pkg::vid_t             id_i,
  input  logic                          use_scalar_i,
  input  valu_vec_pkg::elen_t           scalar_i,
  input  logic                          insn_valid_i,
  output logic                          insn_ready_o,
  // Operands
  input  valu_vec_pkg::elen_t [1:0]     operand_i,
  input  logic                [1:0]     operand_valid_i,
  output logic                [1:0]     operand_ready_o,
  // Register-file write port
  output logic                          result_req_o,
  output valu_op_pkg::vid_t             result_id_o,
  output valu_vec_pkg::vaddr_t          result_addr_o,
  output valu_vec_pkg::elen_t           result_wdata_o,
  output valu_vec_pkg::strb_t           result_be_o,
  input  logic                          result_gnt_i,
  // Completion
  output valu_op_pkg::vinsn_done_t      done_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  // Issue head
  logic     issue_valid, issue_use_scalar, issue_pop;
  valu_op_e issue_op;
  vew_e     issue_vsew;
  vlen_t    issue_vl;
  vreg_t    issue_vd;
  vid_t     issue_id;
  elen_t    issue_scalar;
  // Commit head
  logic     commit_valid, commit_pop;
  vlen_t    commit_vl;
  vew_e     commit_vsew;
  vid_t     commit_id;
  // Issue to result queue
  logic     push, full, word_retired;
  vid_t     push_id;
  vaddr_t   push_addr;
  elen_t    push_wdata;
  strb_t    push_be;

  valu_insn_queue u_insn_queue (
    .clk_i, .rst_ni, .op_i, .vsew_i, .vl_i, .vd_i, .id_i,
    .use_scalar_i, .scalar_i, .insn_valid_i, .insn_ready_o,
    .issue_valid_o      (issue_valid),
    .issue_op_o         (issue_op),
    .issue_vsew_o       (issue_vsew),
    .issue_vl_o         (issue_vl),
    .issue_vd_o         (issue_vd),
    .issue_id_o         (issue_id),
    .issue_use_scalar_o (issue_use_scalar),
    .issue_scalar_o     (issue_scalar),
    .issue_pop_i        (issue_pop),
    .commit_valid_o     (commit_valid),
    .commit_vl_o        (commit_vl),
    .commit_vsew_o      (commit_vsew),
    .commit_id_o        (commit_id),
    .commit_pop_i       (commit_pop)
  );

  valu_issue u_issue (
    .clk_i, .rst_ni,
    .issue_valid_i      (issue_valid),
    .issue_op_i         (issue_op),
    .issue_vsew_i       (issue_vsew),
    .issue_vl_i         (issue_vl),
    .issue_vd_i         (issue_vd),
    .issue_id_i         (issue_id),
    .issue_use_scalar_i (issue_use_scalar),
    .issue_scalar_i     (issue_scalar),
    .issue_pop_o        (issue_pop),
    .operand_i, .operand_valid_i, .operand_ready_o,
    .full_i             (full),
    .push_o             (push),
    .push_id_o          (push_id),
    .push_addr_o        (push_addr),
    .push_wdata_o       (push_wdata),
    .push_be_o          (push_be)
  );

  valu_result_queue u_result_queue (
    .clk_i, .rst_ni,
    .push_i         (push),
    .push_id_i      (push_id),
    .push_addr_i    (push_addr),
    .push_wdata_i   (push_wdata),
    .push_be_i      (push_be),
    .full_o         (full),
    .result_req_o, .result_id_o, .result_addr_o, .result_wdata_o, .result_be_o,
    .result_gnt_i,
    .word_retired_o (word_retired)
  );

  valu_commit u_commit (
    .clk_i, .rst_ni,
    .word_retired_i (word_retired),
    .commit_valid_i (commit_valid),
    .commit_vl_i    (commit_vl),
    .commit_vsew_i  (commit_vsew),
    .commit_id_i    (commit_id),
    .commit_pop_o   (commit_pop),
    .done_o
  );

endmodule

// ==== rtl/valu_commit.sv ====
`timescale 1ns/1ps
/*
 * Commit tracker of the ALU lane
 * Counts written elements and signals completion per instruction
 */
module valu_commit (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      word_retired_i,
  // Commit head of the instruction queue
  input  logic                      commit_valid_i,
  input  valu_vec_pkg::vlen_t       commit_vl_i,
  input  valu_vec_pkg::vew_e        commit_vsew_i,
  input  valu_op_pkg::vid_t         commit_id_i,
  output logic                      commit_pop_o,
  output valu_op_pkg::vinsn_done_t  done_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  vlen_t committed_q;
  vlen_t committed_next;

  // A full word of elements, the last one may be partial
  assign committed_next = committed_q + (vlen_t'(4'd8) >> commit_vsew_i);

  // Last word granted this cycle
  assign commit_pop_o = word_retired_i && commit_valid_i && (committed_next >= commit_vl_i);
  assign done_o       = commit_pop_o ? vinsn_done_t'(1) << commit_id_i : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      committed_q <= '0;
    end else if (word_retired_i) begin
      committed_q <= commit_pop_o ? '0 : committed_next;
    end
  end

  // Every word written belongs to an instruction still held in the queue
  a_retire_has_insn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_retired_i |-> commit_valid_i);

endmodule

// ==== rtl/valu_insn_queue.sv ====
`timescale 1ns/1ps
/*
 * Instruction store of the ALU lane
 * Holds accepted instructions and exposes an issue head and a commit head
 */
`include "valu_settings.svh"

module valu_insn_queue (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // New instruction
  input  valu_op_pkg::valu_op_e    op_i,
  input  valu_vec_pkg::vew_e       vsew_i,
  input  valu_vec_pkg::vlen_t      vl_i,
  input  valu_vec_pkg::vreg_t      vd_i,
  input  valu_op_pkg::vid_t        id_i,
  input  logic                     use_scalar_i,
  input  valu_vec_pkg::elen_t      scalar_i,
  input  logic                     insn_valid_i,
  output logic                     insn_ready_o,
  // Issue head
  output logic                     issue_valid_o,
  output valu_op_pkg::valu_op_e    issue_op_o,
  output valu_vec_pkg::vew_e       issue_vsew_o,
  output valu_vec_pkg::vlen_t      issue_vl_o,
  output valu_vec_pkg::vreg_t      issue_vd_o,
  output valu_op_pkg::vid_t        issue_id_o,
  output logic                     issue_use_scalar_o,
  output valu_vec_pkg::elen_t      issue_scalar_o,
  input  logic                     issue_pop_i,
  // Commit head
  output logic                     commit_valid_o,
  output valu_vec_pkg::vlen_t      commit_vl_o,
  output valu_vec_pkg::vew_e       commit_vsew_o,
  output valu_op_pkg::vid_t        commit_id_o,
  input  logic                     commit_pop_i
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  localparam int unsigned Depth = `VALU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  // Instruction fields, one array each
  valu_op_e op_q         [Depth];
  vew_e     vsew_q       [Depth];
  vlen_t    vl_q         [Depth];
  vreg_t    vd_q         [Depth];
  vid_t     id_q         [Depth];
  logic     use_scalar_q [Depth];
  elen_t    scalar_q     [Depth];

  // Pointers wrap over the power-of-two depth
  logic [PntW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions still to issue, and still to commit
  logic [PntW:0]   issue_cnt_q, commit_cnt_q;
  logic            accept;

  // An instruction holds its slot until its last word commits
  assign insn_ready_o = (commit_cnt_q != (PntW+1)'(Depth));
  assign accept       = insn_valid_i && insn_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= op_i;
      vsew_q[accept_pnt_q]       <= vsew_i;
      vl_q[accept_pnt_q]         <= vl_i;
      vd_q[accept_pnt_q]         <= vd_i;
      id_q[accept_pnt_q]         <= id_i;
      use_scalar_q[accept_pnt_q] <= use_scalar_i;
      scalar_q[accept_pnt_q]     <= scalar_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_pop_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_pop_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      issue_cnt_q  <= issue_cnt_q + (PntW+1)'(accept) - (PntW+1)'(issue_pop_i);
      commit_cnt_q <= commit_cnt_q + (PntW+1)'(accept) - (PntW+1)'(commit_pop_i);
    end
  end

  // Issue head
  assign issue_valid_o      = (issue_cnt_q != '0);
  assign issue_op_o         = op_q[issue_pnt_q];
  assign issue_vsew_o       = vsew_q[issue_pnt_q];
  assign issue_vl_o         = vl_q[issue_pnt_q];
  assign issue_vd_o         = vd_q[issue_pnt_q];
  assign issue_id_o         = id_q[issue_pnt_q];
  assign issue_use_scalar_o = use_scalar_q[issue_pnt_q];
  assign issue_scalar_o     = scalar_q[issue_pnt_q];

  // Commit head
  assign commit_valid_o = (commit_cnt_q != '0);
  assign commit_vl_o    = vl_q[commit_pnt_q];
  assign commit_vsew_o  = vsew_q[commit_pnt_q];
  assign commit_id_o    = id_q[commit_pnt_q];

  // Issue and commit only ever retire an instruction that is present
  a_issue_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_pop_i |-> issue_valid_o);
  a_commit_pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_pop_i |-> commit_valid_o);

endmodule

// ==== rtl/valu_issue.sv ====
`timescale 1ns/1ps
/*
 * Word issue stage of the ALU lane
 * Walks the issue-head instruction one word at a time and pushes results
 */
`include "valu_settings.svh"

module valu_issue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Issue head of the instruction queue
  input  logic                         issue_valid_i,
  input  valu_op_pkg::valu_op_e        issue_op_i,
  input  valu_vec_pkg::vew_e           issue_vsew_i,
  input  valu_vec_pkg::vlen_t          issue_vl_i,
  input  valu_vec_pkg::vreg_t          issue_vd_i,
  input  valu_op_pkg::vid_t            issue_id_i,
  input  logic                         issue_use_scalar_i,
  input  valu_vec_pkg::elen_t          issue_scalar_i,
  output logic                         issue_pop_o,
  // Operand queues
  input  valu_vec_pkg::elen_t [1:0]    operand_i,
  input  logic                [1:0]    operand_valid_i,
  output logic                [1:0]    operand_ready_o,
  // Result queue
  input  logic                         full_i,
  output logic                         push_o,
  output valu_op_pkg::vid_t            push_id_o,
  output valu_vec_pkg::vaddr_t         push_addr_o,
  output valu_vec_pkg::elen_t          push_wdata_o,
  output valu_vec_pkg::strb_t          push_be_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  // Elements of the current instruction issued so far
  vlen_t      issued_q;
  vlen_t      remaining;
  logic [3:0] elem_per_word;
  logic [3:0] elem_cnt;
  logic [3:0] nbytes;
  logic       operands_ok;
  logic       last_word;
  elen_t      scalar_rep;
  elen_t      alu_a;

  // 8 >> log2(bytes) gives elements per word
  assign elem_per_word = 4'd8 >> issue_vsew_i;
  assign remaining     = issue_vl_i - issued_q;
  // Partial last word
  assign elem_cnt      = (remaining < vlen_t'(elem_per_word)) ? remaining[3:0] : elem_per_word;
  assign nbytes        = elem_cnt << issue_vsew_i;

  // Slot 1 always needed, slot 0 only for vector-vector forms
  assign operands_ok = operand_valid_i[1] && (issue_use_scalar_i || operand_valid_i[0]);
  assign push_o      = issue_valid_i && !full_i && operands_ok;
  assign last_word   = (issued_q + vlen_t'(elem_cnt)) >= issue_vl_i;
  assign issue_pop_o = push_o && last_word;

  // Operands are consumed in the cycle the word issues
  assign operand_ready_o = push_o ? {1'b1, !issue_use_scalar_i} : 2'b00;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= '0;
    end else if (push_o) begin
      // Restart at zero for the next instruction
      issued_q <= last_word ? '0 : issued_q + vlen_t'(elem_cnt);
    end
  end

  // Replicate the low SEW bits of the scalar over the word
  always_comb begin
    case (issue_vsew_i)
      EW8:     scalar_rep = {8{issue_scalar_i[7:0]}};
      EW16:    scalar_rep = {4{issue_scalar_i[15:0]}};
      EW32:    scalar_rep = {2{issue_scalar_i[31:0]}};
      default: scalar_rep = issue_scalar_i;
    endcase
  end

  assign alu_a = issue_use_scalar_i ? scalar_rep : operand_i[0];

  valu_simd_alu u_simd_alu (
    .a_i      (alu_a),
    .b_i      (operand_i[1]),
    .op_i     (issue_op_i),
    .vsew_i   (issue_vsew_i),
    .result_o (push_wdata_o)
  );

  assign push_id_o = issue_id_i;

  // Register base plus the index of this word inside the register
  assign push_addr_o = vaddr_t'(issue_vd_i) * vaddr_t'(`VALU_VREG_WORDS)
                     + vaddr_t'(issued_q >> (2'd3 - issue_vsew_i));

  // Low bytes cover the elements of this word
  always_comb begin
    for (int i = 0; i < $bits(strb_t); i++) begin
      push_be_o[i] = (i < nbytes);
    end
  end

endmodule

// ==== rtl/valu_op_pkg.sv ====
/*
 * Operation types of the ALU lane
 * Opcode encoding, instruction ids and the done vector
 */
`include "valu_settings.svh"

package valu_op_pkg;

  // Integer operations supported by the lane
  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4
  } valu_op_e;

  // Instruction id handed in by the sequencer
  typedef logic [$clog2(`VALU_NR_VINSN)-1:0] vid_t;

  // One bit per instruction id
  typedef logic [`VALU_NR_VINSN-1:0] vinsn_done_t;

endpackage

// ==== rtl/valu_result_queue.sv ====
`timescale 1ns/1ps
/*
 * Result buffer of the ALU lane
 * Two-entry FIFO whose head drives the register-file write request
 */
`include "valu_settings.svh"

module valu_result_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Write side from the issue stage
  input  logic                  push_i,
  input  valu_op_pkg::vid_t     push_id_i,
  input  valu_vec_pkg::vaddr_t  push_addr_i,
  input  valu_vec_pkg::elen_t   push_wdata_i,
  input  valu_vec_pkg::strb_t   push_be_i,
  output logic                  full_o,
  // Register-file write port
  output logic                  result_req_o,
  output valu_op_pkg::vid_t     result_id_o,
  output valu_vec_pkg::vaddr_t  result_addr_o,
  output valu_vec_pkg::elen_t   result_wdata_o,
  output valu_vec_pkg::strb_t   result_be_o,
  input  logic                  result_gnt_i,
  // One pulse per word written
  output logic                  word_retired_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  localparam int unsigned Depth = `VALU_RESULT_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  // Payload storage
  vid_t   id_q    [Depth];
  vaddr_t addr_q  [Depth];
  elen_t  wdata_q [Depth];
  strb_t  be_q    [Depth];

  logic [PntW-1:0] wr_pnt_q, rd_pnt_q;
  logic [PntW:0]   cnt_q;
  logic            pop;

  assign full_o       = (cnt_q == (PntW+1)'(Depth));
  assign result_req_o = (cnt_q != '0);
  // Head leaves in the grant cycle
  assign pop            = result_req_o && result_gnt_i;
  assign word_retired_o = pop;

  assign result_id_o    = id_q[rd_pnt_q];
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_pnt_q]    <= push_id_i;
      addr_q[wr_pnt_q]  <= push_addr_i;
      wdata_q[wr_pnt_q] <= push_wdata_i;
      be_q[wr_pnt_q]    <= push_be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      // Push and pop may coincide
      cnt_q <= cnt_q + (PntW+1)'(push_i) - (PntW+1)'(pop);
    end
  end

  // Issue stage honours the full flag
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

  // A pending request holds its payload until granted
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_id_o)
      && $stable(result_addr_o) && $stable(result_wdata_o) && $stable(result_be_o));

endmodule

// ==== rtl/valu_simd_alu.sv ====
`timescale 1ns/1ps
/*
 * SIMD integer datapath of the ALU lane
 * Element-wise add and subtract plus bitwise logic on one word
 */
module valu_simd_alu (
  input  valu_vec_pkg::elen_t   a_i,
  input  valu_vec_pkg::elen_t   b_i,
  input  valu_op_pkg::valu_op_e op_i,
  input  valu_vec_pkg::vew_e    vsew_i,
  output valu_vec_pkg::elen_t   result_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  logic sub;

  // Subtract is b minus a, as vs2 minus vs1
  assign sub = (op_i == VSUB);

  always_comb begin
    result_o = '0;
    case (op_i)
      VAND: result_o = a_i & b_i;
      VOR:  result_o = a_i | b_i;
      VXOR: result_o = a_i ^ b_i;
      VADD, VSUB: begin
        // Separate adders per element, so no carry crosses a boundary
        case (vsew_i)
          EW8: begin
            for (int i = 0; i < 8; i++) begin
              result_o[8*i +: 8] = sub ? b_i[8*i +: 8] - a_i[8*i +: 8]
                                       : b_i[8*i +: 8] + a_i[8*i +: 8];
            end
          end
          EW16: begin
            for (int i = 0; i < 4; i++) begin
              result_o[16*i +: 16] = sub ? b_i[16*i +: 16] - a_i[16*i +: 16]
                                         : b_i[16*i +: 16] + a_i[16*i +: 16];
            end
          end
          EW32: begin
            for (int i = 0; i < 2; i++) begin
              result_o[32*i +: 32] = sub ? b_i[32*i +: 32] - a_i[32*i +: 32]
                                         : b_i[32*i +: 32] + a_i[32*i +: 32];
            end
          end
          default: result_o = sub ? b_i - a_i : b_i + a_i;
        endcase
      end
      default: result_o = '0;
    endcase
  end

endmodule

// ==== rtl/valu_vec_pkg.sv ====
/*
 * Vector data types of the ALU lane
 * Data word, byte enables, element width, lengths and addresses
 */
`include "valu_settings.svh"

package valu_vec_pkg;

  // One data word and its byte enables
  typedef logic [`VALU_ELEN-1:0]   elen_t;
  typedef logic [`VALU_ELEN/8-1:0] strb_t;

  // Standard element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Element count, wide enough for a full register of bytes
  typedef logic [$clog2(`VALU_VREG_WORDS * `VALU_ELEN / 8):0] vlen_t;

  // Register number and lane word address
  typedef logic [4:0]                               vreg_t;
  typedef logic [$clog2(32 * `VALU_VREG_WORDS)-1:0] vaddr_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the vector ALU lane testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_valu --Mdir obj_dir -o tb_valu -f valu.f

# The log decides the outcome
./obj_dir/tb_valu | tee sim.log

if grep -q "^All checks passed$" sim.log; then
  exit 0
fi
exit 1

// ==== tests/tb_valu.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the vector ALU lane
 * Random instructions, operands and grants, checked by the scoreboard
 */
module tb_valu;

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  localparam int NumInsn   = 60;
  localparam int WaitLimit = 4000;

  logic                clk_i;
  logic                rst_ni;
  valu_op_e            op_i;
  vew_e                vsew_i;
  vlen_t               vl_i;
  vreg_t               vd_i;
  vid_t                id_i;
  logic                use_scalar_i;
  elen_t               scalar_i;
  logic                insn_valid_i;
  logic                insn_ready_o;
  elen_t [1:0]         operand_i;
  logic  [1:0]         operand_valid_i;
  logic  [1:0]         operand_ready_o;
  logic                result_req_o;
  vid_t                result_id_o;
  vaddr_t              result_addr_o;
  elen_t               result_wdata_o;
  strb_t               result_be_o;
  logic                result_gnt_i;
  vinsn_done_t         done_o;

  int errors;
  int dones;
  int timeouts;
  // Cycles left in a forced grant stall
  int stall_left;

  valu u_valu (.*);

  valu_checker u_checker (
    .clk_i, .rst_ni, .op_i, .vsew_i, .vl_i, .vd_i, .id_i, .use_scalar_i, .scalar_i,
    .insn_valid_i,
    .insn_ready_i    (insn_ready_o),
    .operand_i, .operand_valid_i,
    .operand_ready_i (operand_ready_o),
    .result_req_i    (result_req_o),
    .result_id_i     (result_id_o),
    .result_addr_i   (result_addr_o),
    .result_wdata_i  (result_wdata_o),
    .result_be_i     (result_be_o),
    .result_gnt_i,
    .done_i          (done_o),
    .error_count_o   (errors),
    .done_count_o    (dones)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  // Operands and grant redrawn every falling edge
  always @(negedge clk_i) begin
    operand_valid_i[0] = ($urandom % 4) != 0;
    operand_valid_i[1] = ($urandom % 4) != 0;
    operand_i[0]       = {$urandom, $urandom};
    operand_i[1]       = {$urandom, $urandom};
    if (stall_left > 0) begin
      stall_left--;
      result_gnt_i = 1'b0;
    end else if (($urandom % 32) == 0) begin
      // Long stall fills both queues and closes the instruction port
      stall_left   = 24 + int'($urandom % 32);
      result_gnt_i = 1'b0;
    end else begin
      result_gnt_i = ($urandom % 2) != 0;
    end
  end

  // Offer one random instruction and hold it until the lane takes it
  task automatic send_insn();
    int waited;
    op_i         = valu_op_e'($urandom % 5);
    vsew_i       = vew_e'($urandom % 4);
    vl_i         = vlen_t'(1 + $urandom % 64);
    vd_i         = vreg_t'($urandom % 32);
    id_i         = vid_t'($urandom % 8);
    use_scalar_i = ($urandom % 2) != 0;
    scalar_i     = {$urandom, $urandom};
    insn_valid_i = 1'b1;
    waited       = 0;
    // Ready moves only on the rising edge, stable here
    while (!insn_ready_o && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!insn_ready_o) begin
      $display("Instruction port stayed closed for %0d cycles", WaitLimit);
      timeouts++;
    end
    @(negedge clk_i);
    insn_valid_i = 1'b0;
  endtask

  task automatic wait_all_done();
    int waited;
    waited = 0;
    while (dones < NumInsn && waited < WaitLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (dones < NumInsn) begin
      $display("Only %0d of %0d instructions completed in time", dones, NumInsn);
      timeouts++;
    end
  endtask

  initial begin
    void'($urandom(5));
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    op_i            = VADD;
    vsew_i          = EW8;
    vl_i            = '0;
    vd_i            = '0;
    id_i            = '0;
    use_scalar_i    = 1'b0;
    scalar_i        = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = 1'b0;
    timeouts        = 0;
    stall_left      = 0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int n = 0; n < NumInsn && timeouts == 0; n++) begin
      send_insn();
      repeat ($urandom % 3) @(negedge clk_i);
    end
    if (timeouts == 0) begin
      wait_all_done();
    end

    $display("Check errors: %0d, timeouts: %0d, instructions done: %0d of %0d",
             errors, timeouts, dones, NumInsn);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tests/valu_checker.sv ====
`timescale 1ns/1ps
/*
 * Scoreboard for the vector ALU lane
 * Models accepted instructions and taken operands, checks writes and done pulses
 */
`include "valu_settings.svh"

module valu_checker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  // Instruction port as seen by the DUT
  input  valu_op_pkg::valu_op_e      op_i,
  input  valu_vec_pkg::vew_e         vsew_i,
  input  valu_vec_pkg::vlen_t        vl_i,
  input  valu_vec_pkg::vreg_t        vd_i,
  input  valu_op_pkg::vid_t          id_i,
  input  logic                       use_scalar_i,
  input  valu_vec_pkg::elen_t        scalar_i,
  input  logic                       insn_valid_i,
  input  logic                       insn_ready_i,
  // Operand port
  input  valu_vec_pkg::elen_t [1:0]  operand_i,
  input  logic                [1:0]  operand_valid_i,
  input  logic                [1:0]  operand_ready_i,
  // Register-file write port
  input  logic                       result_req_i,
  input  valu_op_pkg::vid_t          result_id_i,
  input  valu_vec_pkg::vaddr_t       result_addr_i,
  input  valu_vec_pkg::elen_t        result_wdata_i,
  input  valu_vec_pkg::strb_t        result_be_i,
  input  logic                       result_gnt_i,
  input  valu_op_pkg::vinsn_done_t   done_i,
  output int                         error_count_o,
  output int                         done_count_o
);

  import valu_vec_pkg::*;
  import valu_op_pkg::*;

  // Field order matches the concatenation used on accept
  typedef struct packed {
    valu_op_e op;
    vew_e     vsew;
    vlen_t    vl;
    vreg_t    vd;
    vid_t     id;
    logic     use_scalar;
    elen_t    scalar;
  } insn_t;

  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } word_t;

  insn_t issue_q[$];
  insn_t commit_q[$];
  // Expected writes in issue order
  word_t word_q[$];
  word_t held;
  logic  was_held;
  logic  in_reset;
  int    issue_words;
  int    commit_words;
  int    outstanding;
  int    errors;
  int    dones;

  assign error_count_o = errors;
  assign done_count_o  = dones;

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] got);
    $display("ERROR %0t %s: expected %0h, got %0h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("At time %0t %s", $time, what);
    errors++;
  endtask

  function automatic int elems_per_word(input vew_e sew);
    return 8 >> sew;
  endfunction

  // Ceiling of vl over elements per word
  function automatic int words_of(input insn_t insn);
    int epw;
    epw = elems_per_word(insn.vsew);
    return (int'(insn.vl) + epw - 1) / epw;
  endfunction

  function automatic elen_t elem_mask(input vew_e sew);
    int bits;
    bits = 8 << sew;
    return (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
  endfunction

  // Each element sliced out by shift and mask
  function automatic elen_t expected_data(input insn_t insn, input elen_t a_in,
                                          input elen_t b_in);
    int    bits;
    elen_t mask;
    elen_t ea;
    elen_t eb;
    elen_t er;
    elen_t res;
    bits = 8 << insn.vsew;
    mask = elem_mask(insn.vsew);
    res  = '0;
    for (int k = 0; k < 64; k += bits) begin
      // Scalar stands in for every element of operand a
      ea = insn.use_scalar ? (insn.scalar & mask) : ((a_in >> k) & mask);
      eb = (b_in >> k) & mask;
      case (insn.op)
        VADD:    er = eb + ea;
        VSUB:    er = eb - ea;
        VAND:    er = eb & ea;
        VOR:     er = eb | ea;
        VXOR:    er = eb ^ ea;
        default: er = '0;
      endcase
      res = res | ((er & mask) << k);
    end
    return res;
  endfunction

  // Bytes of the elements left in this word
  function automatic strb_t expected_be(input insn_t insn, input int word);
    int epw;
    int left;
    int nbytes;
    epw  = elems_per_word(insn.vsew);
    left = int'(insn.vl) - word * epw;
    if (left > epw) begin
      left = epw;
    end
    nbytes = left * (1 << insn.vsew);
    return strb_t'((9'd1 << nbytes) - 9'd1);
  endfunction

  always @(posedge clk_i) begin
    insn_t       insn;
    word_t       exp_w;
    vinsn_done_t exp_done;
    if (!rst_ni) begin
      issue_q.delete();
      commit_q.delete();
      word_q.delete();
      issue_words  = 0;
      commit_words = 0;
      outstanding  = 0;
      was_held     = 1'b0;
      in_reset     = 1'b1;
    end else begin
      // First cycle out of reset shows the idle state
      if (in_reset) begin
        if (insn_ready_i !== 1'b1) report_mismatch("insn_ready_o", 1, insn_ready_i);
        if (result_req_i !== 1'b0) report_mismatch("result_req_o", 0, result_req_i);
        if (operand_ready_i !== 2'b00) report_mismatch("operand_ready_o", 0, operand_ready_i);
        if (done_i !== '0) report_mismatch("done_o", 0, done_i);
        in_reset = 1'b0;
      end

      // A request left waiting must come back unchanged
      if (was_held) begin
        if (!result_req_i) begin
          report_failure("result_req_o dropped before its grant");
        end else begin
          if (result_id_i != held.id) report_mismatch("result_id_o", held.id, result_id_i);
          if (result_addr_i != held.addr) begin
            report_mismatch("result_addr_o", held.addr, result_addr_i);
          end
          if (result_wdata_i != held.wdata) begin
            report_mismatch("result_wdata_o", held.wdata, result_wdata_i);
          end
          if (result_be_i != held.be) report_mismatch("result_be_o", held.be, result_be_i);
        end
      end
      was_held = result_req_i && !result_gnt_i;
      held     = {result_id_i, result_addr_i, result_wdata_i, result_be_i};

      // Four instructions in flight close the instruction port
      if (insn_ready_i != (outstanding < `VALU_INSN_DEPTH)) begin
        report_mismatch("insn_ready_o", outstanding < `VALU_INSN_DEPTH, insn_ready_i);
      end

      // Granted word against the oldest expected one
      exp_done = '0;
      if (result_req_i && result_gnt_i) begin
        if (word_q.size() == 0 || commit_q.size() == 0) begin
          report_failure("a word was granted that no issued operands account for");
        end else begin
          exp_w = word_q.pop_front();
          if (result_id_i != exp_w.id) report_mismatch("result_id_o", exp_w.id, result_id_i);
          if (result_addr_i != exp_w.addr) begin
            report_mismatch("result_addr_o", exp_w.addr, result_addr_i);
          end
          if (result_wdata_i != exp_w.wdata) begin
            report_mismatch("result_wdata_o", exp_w.wdata, result_wdata_i);
          end
          if (result_be_i != exp_w.be) report_mismatch("result_be_o", exp_w.be, result_be_i);
          commit_words++;
          // Last word of the oldest instruction
          if (commit_words == words_of(commit_q[0])) begin
            insn         = commit_q.pop_front();
            exp_done     = vinsn_done_t'(1) << insn.id;
            commit_words = 0;
            outstanding--;
            dones++;
          end
        end
      end
      if (done_i != exp_done) report_mismatch("done_o", exp_done, done_i);

      // Operands taken this cycle make the next expected word
      if (operand_ready_i != 2'b00) begin
        if (issue_q.size() == 0) begin
          report_failure("operands were taken with no instruction waiting");
        end else begin
          insn = issue_q[0];
          if (operand_ready_i != {1'b1, !insn.use_scalar}) begin
            report_mismatch("operand_ready_o", {1'b1, !insn.use_scalar}, operand_ready_i);
          end
          if (!operand_valid_i[1] || (!insn.use_scalar && !operand_valid_i[0])) begin
            report_failure("operands were taken while not valid");
          end
          exp_w.id    = insn.id;
          exp_w.addr  = vaddr_t'(int'(insn.vd) * `VALU_VREG_WORDS + issue_words);
          exp_w.wdata = expected_data(insn, operand_i[0], operand_i[1]);
          exp_w.be    = expected_be(insn, issue_words);
          word_q.push_back(exp_w);
          issue_words++;
          if (issue_words == words_of(insn)) begin
            issue_q.delete(0);
            issue_words = 0;
          end
        end
      end

      if (insn_valid_i && insn_ready_i) begin
        insn = {op_i, vsew_i, vl_i, vd_i, id_i, use_scalar_i, scalar_i};
        issue_q.push_back(insn);
        commit_q.push_back(insn);
        outstanding++;
      end
    end
  end

endmodule

// ==== valu.f ====
+incdir+.
rtl/valu_vec_pkg.sv
rtl/valu_op_pkg.sv
rtl/valu_simd_alu.sv
rtl/valu_insn_queue.sv
rtl/valu_issue.sv
rtl/valu_result_queue.sv
rtl/valu_commit.sv
rtl/valu.sv
tests/valu_checker.sv
tests/tb_valu.sv

// ==== valu_settings.svh ====
/*
 * Vector ALU lane sizing
 * Word width, queue depths, id space and register-file geometry
 */
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// Data word processed per cycle
`define VALU_ELEN 64
// Instructions held from accept until commit
`define VALU_INSN_DEPTH 4
// Words waiting for a register-file grant
`define VALU_RESULT_DEPTH 2
// Size of the instruction id space
`define VALU_NR_VINSN 8
// Words of one vector register held in this lane
`define VALU_VREG_WORDS 32

`endif
